// ==== rtl/armPkg.sv ====
`default_nettype none

package armPkg;

   localparam int WordWidth    = 32;
   localparam int RegAddrWidth = 4;
   localparam int ShamtWidth   = 5;    // Immediate shift amount field

   typedef logic [WordWidth-1:0]    wordT;
   typedef logic [RegAddrWidth-1:0] regAddrT;

   localparam regAddrT PcReg   = 4'd15;  // Reads as pc + 8
   localparam regAddrT LinkReg = 4'd14;  // BL return address
   localparam wordT    PcStep  = 32'd4;

   // Data-processing function field, instr[24:21]
   localparam logic [3:0] FnAnd = 4'b0000;
   localparam logic [3:0] FnEor = 4'b0001;
   localparam logic [3:0] FnSub = 4'b0010;
   localparam logic [3:0] FnAdd = 4'b0100;
   localparam logic [3:0] FnTst = 4'b1000;
   localparam logic [3:0] FnCmp = 4'b1010;
   localparam logic [3:0] FnOrr = 4'b1100;
   localparam logic [3:0] FnMov = 4'b1101;
   localparam logic [3:0] FnBic = 4'b1110;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flagsT;

   typedef enum logic [3:0] {
      EQ = 4'b0000, NE = 4'b0001, CS = 4'b0010, CC = 4'b0011,
      MI = 4'b0100, PL = 4'b0101, VS = 4'b0110, VC = 4'b0111,
      HI = 4'b1000, LS = 4'b1001, GE = 4'b1010, LT = 4'b1011,
      GT = 4'b1100, LE = 4'b1101, AL = 4'b1110
   } condT;

   typedef enum logic [2:0] {
      AluAdd = 3'd0, AluSub = 3'd1, AluAnd = 3'd2, AluOrr = 3'd3,
      AluEor = 3'd4, AluBic = 3'd5, AluMov = 3'd6
   } aluOpT;

   typedef enum logic [1:0] {
      Imm8 = 2'b00, Imm12 = 2'b01, ImmBranch = 2'b10
   } immSrcT;

   // Same values as instr[27:26]
   typedef enum logic [1:0] {
      OpData = 2'b00, OpMem = 2'b01, OpBranch = 2'b10
   } opClassT;

endpackage

`default_nettype wire

// ==== rtl/armCtrlIf.sv ====
`default_nettype none

interface armCtrlIf;

   // Decoded, before the condition check
   logic [2:0] regSrc;        // [0] ra1=pc, [1] ra2=rd, [2] wa=lr
   logic [1:0] immSrc;
   logic       aluSrc;        // Immediate second operand
   logic [2:0] aluOp;
   logic       memToReg;
   logic       setFlags;      // NZ enable
   logic       setCarry;      // CV enable
   logic       link;          // Write pc + 4 instead of result
   logic       decRegWrite;
   logic       decMemWrite;
   logic       decPcWrite;

   // Qualified by condition and pcReady
   logic       regWrite;
   logic       memWriteEn;
   logic       pcSrc;

   logic [3:0] aluFlags;      // n, z, c, v

   modport decoder (output regSrc, immSrc, aluSrc, aluOp, memToReg, setFlags,
                    setCarry, link, decRegWrite, decMemWrite, decPcWrite);
   modport condition (input decRegWrite, decMemWrite, decPcWrite, setFlags,
                      setCarry, aluFlags, output regWrite, memWriteEn, pcSrc);
   modport datapath (input regSrc, immSrc, aluSrc, aluOp, memToReg, link,
                     regWrite, pcSrc, output aluFlags);

endinterface

`default_nettype wire

// ==== rtl/armDecoder.sv ====
`default_nettype none

module armDecoder
   import armPkg::*;
(
   input  wordT      instr,
   armCtrlIf.decoder ctrl
);

   opClassT    opClass;
   logic [5:0] funct;     // I, opcode, S / L
   logic [3:0] fn;
   logic       sBit;      // S for data, L for memory
   logic       isData;
   logic       noWrite;
   logic       branch;
   logic       regW;
   logic       memW;

   assign opClass = opClassT'(instr[27:26]);
   assign funct   = instr[25:20];
   assign fn      = funct[4:1];
   assign sBit    = funct[0];
   assign isData  = (opClass == OpData);
   assign noWrite = (fn == FnCmp) | (fn == FnTst);  // Flags only

   // Main decoder
   always_comb
   begin
      branch        = 1'b0;
      regW          = 1'b0;
      memW          = 1'b0;
      ctrl.regSrc   = 3'b000;
      ctrl.immSrc   = Imm8;
      ctrl.aluSrc   = 1'b0;
      ctrl.memToReg = 1'b0;
      ctrl.link     = 1'b0;
      case (opClass)
         OpData:
         begin
            ctrl.aluSrc = funct[5];    // I bit
            regW        = ~noWrite;
         end
         OpMem:
         begin
            ctrl.immSrc   = Imm12;
            ctrl.aluSrc   = 1'b1;
            ctrl.memToReg = sBit;      // LDR
            regW          = sBit;
            memW          = ~sBit;     // STR
            ctrl.regSrc   = {1'b0, ~sBit, 1'b0};  // Store data from rd
         end
         OpBranch:
         begin
            branch      = 1'b1;
            ctrl.immSrc = ImmBranch;
            ctrl.aluSrc = 1'b1;
            ctrl.link   = funct[4];    // BL
            regW        = funct[4];
            ctrl.regSrc = {funct[4], 1'b0, 1'b1};  // Base is pc + 8
         end
         default:
            branch = 1'b0;
      endcase
   end

   // ALU decoder
   always_comb
   begin
      ctrl.aluOp    = AluAdd;   // Address and branch target add
      ctrl.setFlags = 1'b0;
      ctrl.setCarry = 1'b0;
      if (isData)
      begin
         case (fn)
            FnAnd, FnTst: ctrl.aluOp = AluAnd;
            FnSub, FnCmp: ctrl.aluOp = AluSub;
            FnEor:        ctrl.aluOp = AluEor;
            FnOrr:        ctrl.aluOp = AluOrr;
            FnBic:        ctrl.aluOp = AluBic;
            FnMov:        ctrl.aluOp = AluMov;
            default:      ctrl.aluOp = AluAdd;
         endcase
         ctrl.setFlags = sBit;
         // C and V only from arithmetic
         ctrl.setCarry = sBit & ((fn == FnAdd) | (fn == FnSub) | (fn == FnCmp));
      end
   end

   assign ctrl.decRegWrite = regW;
   assign ctrl.decMemWrite = memW;
   assign ctrl.decPcWrite  = ((instr[15:12] == PcReg) & regW) | branch;

endmodule

`default_nettype wire

// ==== rtl/condUnit.sv ====
`default_nettype none

module condUnit
   import armPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        pcReady,
   input  condT        cond,
   armCtrlIf.condition ctrl
);

   logic [1:0] nzQ;
   logic [1:0] cvQ;
   flagsT      flags;
   flagsT      aluFlags;
   logic       nEqV;
   logic       condEx;
   logic       commit;    // Condition holds and core advances

   assign flags    = {nzQ, cvQ};
   assign aluFlags = ctrl.aluFlags;
   assign nEqV     = (flags.n == flags.v);

   always_comb
   begin
      case (cond)
         EQ:      condEx = flags.z;
         NE:      condEx = ~flags.z;
         CS:      condEx = flags.c;
         CC:      condEx = ~flags.c;
         MI:      condEx = flags.n;
         PL:      condEx = ~flags.n;
         VS:      condEx = flags.v;
         VC:      condEx = ~flags.v;
         HI:      condEx = flags.c & ~flags.z;
         LS:      condEx = ~flags.c | flags.z;
         GE:      condEx = nEqV;
         LT:      condEx = ~nEqV;
         GT:      condEx = ~flags.z & nEqV;
         LE:      condEx = flags.z | ~nEqV;
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;  // 1111 never executes
      endcase
   end

   assign commit = condEx & pcReady;

   // NZ pair
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         nzQ <= 2'b00;
      else if (ctrl.setFlags & commit)
         nzQ <= {aluFlags.n, aluFlags.z};
   end

   // CV pair, arithmetic only
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cvQ <= 2'b00;
      else if (ctrl.setCarry & commit)
         cvQ <= {aluFlags.c, aluFlags.v};
   end

   assign ctrl.regWrite   = ctrl.decRegWrite & commit;
   assign ctrl.memWriteEn = ctrl.decMemWrite & commit & ~reset;
   assign ctrl.pcSrc      = ctrl.decPcWrite & commit;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile
   import armPkg::*;
(
   input  logic    clk,
   input  logic    we,
   input  regAddrT ra1,
   input  regAddrT ra2,
   input  regAddrT wa,
   input  wordT    wd,
   input  wordT    r15,    // pc + 8
   output wordT    rd1,
   output wordT    rd2
);

   wordT regs [PcReg];     // r0 to r14

   // r15 lives in the datapath pc register
   always_ff @(posedge clk)
   begin
      if (we && (wa != PcReg))
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == PcReg) ? r15 : regs[ra1];
   assign rd2 = (ra2 == PcReg) ? r15 : regs[ra2];

endmodule

`default_nettype wire

// ==== rtl/armAlu.sv ====
`default_nettype none

module armAlu
   import armPkg::*;
(
   input  wordT                  a,
   input  wordT                  b,
   input  aluOpT                 aluOp,
   input  logic [1:0]            shiftType,
   input  logic [ShamtWidth-1:0] shamt,
   output wordT                  result,
   output flagsT                 flags
);

   logic               isSub;
   logic               isArith;
   wordT               bInv;
   logic [WordWidth:0] sum;     // Top bit is carry out
   wordT               shifted;

   assign isSub   = (aluOp == AluSub);
   assign isArith = (aluOp == AluAdd) | isSub;
   assign bInv    = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bInv} + {{WordWidth{1'b0}}, isSub};

   // MOV shifter
   always_comb
   begin
      case (shiftType)
         2'b00:   shifted = b << shamt;              // LSL
         2'b01:   shifted = b >> shamt;              // LSR
         2'b10:   shifted = $signed(b) >>> shamt;    // ASR
         default: shifted = b;                       // ROR not supported
      endcase
   end

   always_comb
   begin
      case (aluOp)
         AluAdd, AluSub: result = sum[WordWidth-1:0];
         AluAnd:         result = a & b;
         AluOrr:         result = a | b;
         AluEor:         result = a ^ b;
         AluBic:         result = a & ~b;
         AluMov:         result = shifted;
         default:        result = '0;
      endcase
   end

   assign flags.n = result[WordWidth-1];
   assign flags.z = (result == '0);
   assign flags.c = isArith & sum[WordWidth];
   // Operands agree in sign, sum does not
   assign flags.v = isArith & (a[WordWidth-1] == bInv[WordWidth-1])
                    & (sum[WordWidth-1] != a[WordWidth-1]);

endmodule

`default_nettype wire

// ==== rtl/armDatapath.sv ====
`default_nettype none

module armDatapath
   import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       pcReady,
   input  wordT       instr,
   input  wordT       readData,
   output wordT       pc,
   output wordT       dataAddr,
   output wordT       writeData,
   armCtrlIf.datapath ctrl
);

   wordT    pcNext, pcPlus4, pcPlus8;
   wordT    extImm;
   wordT    srcA, srcB;
   wordT    aluResult;
   wordT    result;
   wordT    regWd;
   regAddrT ra1, ra2, wa;
   logic [ShamtWidth-1:0] shamt;

   // Program counter, stalls while pcReady is low
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (pcReady)
         pc <= pcNext;
   end

   assign pcPlus4 = pc + PcStep;
   assign pcPlus8 = pcPlus4 + PcStep;
   assign pcNext  = ctrl.pcSrc ? result : pcPlus4;  // Branch or write to r15

   always_comb
   begin
      case (immSrcT'(ctrl.immSrc))
         Imm8:      extImm = {24'b0, instr[7:0]};
         Imm12:     extImm = {20'b0, instr[11:0]};
         ImmBranch: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};  // Word offset
         default:   extImm = '0;
      endcase
   end

   assign ra1   = ctrl.regSrc[0] ? PcReg : instr[19:16];
   assign ra2   = ctrl.regSrc[1] ? instr[15:12] : instr[3:0];
   assign wa    = ctrl.regSrc[2] ? LinkReg : instr[15:12];
   assign regWd = ctrl.link ? pcPlus4 : result;   // BL return address

   regFile i_regFile (
      .clk (clk),
      .we  (ctrl.regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (wa),
      .wd  (regWd),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   assign srcB  = ctrl.aluSrc ? extImm : writeData;
   // Shift field overlaps the immediate
   assign shamt = ctrl.aluSrc ? '0 : instr[11:7];

   armAlu i_armAlu (
      .a         (srcA),
      .b         (srcB),
      .aluOp     (aluOpT'(ctrl.aluOp)),
      .shiftType (instr[6:5]),
      .shamt     (shamt),
      .result    (aluResult),
      .flags     (ctrl.aluFlags)
   );

   assign dataAddr = aluResult;
   assign result   = ctrl.memToReg ? readData : aluResult;

endmodule

`default_nettype wire

// ==== rtl/armCore.sv ====
`default_nettype none

module armCore
   import armPkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic pcReady,     // Level, low stalls the core
   input  wordT instr,
   input  wordT readData,    // Combinational read, same cycle
   output wordT pc,
   output wordT dataAddr,
   output wordT writeData,
   output logic memWrite
);

   armCtrlIf ctrlIf ();

   armDecoder i_armDecoder (
      .instr (instr),
      .ctrl  (ctrlIf.decoder)
   );

   // Condition field is instr[31:28]
   condUnit i_condUnit (
      .clk     (clk),
      .reset   (reset),
      .pcReady (pcReady),
      .cond    (condT'(instr[31:28])),
      .ctrl    (ctrlIf.condition)
   );

   armDatapath i_armDatapath (
      .clk       (clk),
      .reset     (reset),
      .pcReady   (pcReady),
      .instr     (instr),
      .readData  (readData),
      .pc        (pc),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .ctrl      (ctrlIf.datapath)
   );

   assign memWrite = ctrlIf.memWriteEn;

endmodule

`default_nettype wire

// ==== tests/armCore_checker.sv ====
`default_nettype none

module armCoreChecker
   import armPkg::*;
(
   input logic clk,
   input logic reset,
   input logic pcReady,
   input logic memWrite,
   input wordT pc
);

   timeunit 1ns;
   timeprecision 100ps;

   resetPc: assert property (@(posedge clk) reset |-> pc == '0)
      else $error("pc is not zero while reset is asserted");

   // Stalled edge leaves pc alone
   stallHold: assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else $error("pc changed across a stalled cycle");

   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("pc is not word aligned");

   resetNoStore: assert property (@(posedge clk) reset |-> !memWrite)
      else $error("memWrite is high while reset is asserted");

endmodule

bind armCore armCoreChecker i_armCoreChecker (
   .clk      (clk),
   .reset    (reset),
   .pcReady  (pcReady),
   .memWrite (memWrite),
   .pc       (pc)
);

`default_nettype wire

// ==== tests/armCoreTb.sv ====
`default_nettype none

module armCoreTb
   import armPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClkPeriod      = 4;
   localparam int ResetCycles    = 4;
   localparam int StallAllowance = 4;    // Cycles allowed per instruction
   localparam int MemWords       = 256;
   localparam int LoadBase       = 200;  // Load slots above the store slots
   localparam int ResetSlot      = 240;  // Word written by the first instruction

   // One instruction's effect on the model
   typedef struct packed {
      logic    memWe;
      wordT    addr;
      wordT    data;
      logic    regWe;
      regAddrT regIdx;
      wordT    regVal;
      logic    nzWe;
      logic    cvWe;
      flagsT   flags;
      wordT    nextPc;
   } stepT;

   logic  clk = 1'b0;
   logic  reset;
   logic  pcReady;
   logic  memWrite;
   wordT  instr;
   wordT  readData;
   wordT  pc;
   wordT  dataAddr;
   wordT  writeData;

   wordT  progMem [MemWords];
   wordT  dataMem [MemWords];
   wordT  mDataMem [MemWords];   // Model copy
   wordT  mRegs [15];
   wordT  mPc;
   flagsT mFlags;
   wordT  haltAddr;
   logic  done;
   int    progLen;
   int    storeSlot;
   int    pcErrors;
   int    storeErrors;
   int    seed;

   armCore i_armCore (
      .clk       (clk),
      .reset     (reset),
      .pcReady   (pcReady),
      .instr     (instr),
      .readData  (readData),
      .pc        (pc),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWrite  (memWrite)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   // Combinational-read memories
   assign instr    = progMem[pc[9:2]];
   assign readData = dataMem[dataAddr[9:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         dataMem[dataAddr[9:2]] <= writeData;
   end

   function automatic wordT encData(condT c, logic [3:0] fn, logic s, regAddrT rd,
                                    regAddrT rn, logic [7:0] imm);
      return {c, 3'b001, fn, s, rn, rd, 4'b0000, imm};
   endfunction

   function automatic wordT encDataReg(condT c, logic [3:0] fn, logic s, regAddrT rd,
                                       regAddrT rn, regAddrT rm, logic [1:0] sh,
                                       logic [4:0] amt);
      return {c, 3'b000, fn, s, rn, rd, amt, sh, 1'b0, rm};
   endfunction

   function automatic wordT encMem(condT c, logic load, regAddrT rd, regAddrT rn,
                                   logic [11:0] off);
      return {c, 2'b01, 5'b01100, load, rn, rd, off};   // Pre-indexed with offset added
   endfunction

   function automatic wordT encBranch(condT c, logic link, logic [23:0] off);
      return {c, 3'b101, link, off};
   endfunction

   task automatic emit(wordT ins);
      progMem[progLen] = ins;
      progLen++;
   endtask

   task automatic emitStore(condT c, regAddrT rd);
      emit(encMem(c, 1'b0, rd, 4'd13, 12'(storeSlot * 4)));  // Own slot per store
      storeSlot++;
   endtask

   task automatic buildProgram();
      logic [3:0] fns [6];
      fns = '{FnAdd, FnSub, FnAnd, FnOrr, FnEor, FnBic};
      // Store waits at address 0 through reset
      emit(encMem(AL, 1'b0, PcReg, PcReg, 12'(ResetSlot * 4 - 8)));
      emit(encData(AL, FnMov, 1'b0, 4'd13, 4'd0, 8'd0));      // Store base
      emit(encData(AL, FnMov, 1'b0, 4'd1, 4'd0, 8'($urandom())));
      emit(encData(AL, FnMov, 1'b0, 4'd2, 4'd0, 8'($urandom())));
      emit(encMem(AL, 1'b1, 4'd3, 4'd13, 12'(LoadBase * 4 + 4 * ($urandom() % 16))));
      emit(encMem(AL, 1'b1, 4'd4, 4'd13, 12'(LoadBase * 4 + 4 * ($urandom() % 16))));
      emitStore(AL, 4'd3);
      emitStore(AL, 4'd4);
      for (int i = 0; i < 6; i++)
      begin
         emit(encData(AL, fns[i], 1'b0, 4'd5, 4'd3, 8'($urandom())));
         emitStore(AL, 4'd5);
         emit(encDataReg(AL, fns[i], 1'b0, 4'd6, 4'd3, 4'd4, 2'b00, 5'd0));
         emitStore(AL, 4'd6);
      end
      for (int sh = 0; sh < 3; sh++)   // LSL, LSR, ASR
      begin
         emit(encDataReg(AL, FnMov, 1'b0, 4'd7, 4'd0, 4'd3, 2'(sh),
                         5'(1 + $urandom() % 31)));
         emitStore(AL, 4'd7);
      end
      // Running sum, a repeated commit under a stall changes r5
      for (int i = 0; i < 16; i++)
         emit(encData(AL, FnAdd, 1'b0, 4'd5, 4'd5, 8'($urandom())));
      emitStore(AL, 4'd5);
      for (int k = 0; k < 6; k++)
      begin
         case (k)   // Flag setters
            0: emit(encDataReg(AL, FnCmp, 1'b1, 4'd0, 4'd1, 4'd2, 2'b00, 5'd0));
            1: emit(encDataReg(AL, FnCmp, 1'b1, 4'd0, 4'd3, 4'd4, 2'b00, 5'd0));
            2: emit(encDataReg(AL, FnCmp, 1'b1, 4'd0, 4'd1, 4'd1, 2'b00, 5'd0));
            3: emit(encDataReg(AL, FnTst, 1'b1, 4'd0, 4'd3, 4'd4, 2'b00, 5'd0));
            4: emit(encDataReg(AL, FnAdd, 1'b1, 4'd8, 4'd3, 4'd4, 2'b00, 5'd0));
            default: emit(encDataReg(AL, FnMov, 1'b1, 4'd9, 4'd0, 4'd4, 2'b10, 5'd1));
         endcase
         for (int c = 0; c < 15; c++)
            emitStore(condT'(c), 4'd3);
      end
      emit(encDataReg(AL, FnMov, 1'b0, 4'd10, 4'd0, PcReg, 2'b00, 5'd0));  // pc + 8
      emitStore(AL, 4'd10);
      emit(encData(AL, FnAdd, 1'b0, 4'd11, PcReg, 8'($urandom())));
      emitStore(AL, 4'd11);
      emit(encData(AL, FnAdd, 1'b0, PcReg, PcReg, 8'd0));     // Jumps over next
      emitStore(AL, 4'd1);
      emit(encBranch(AL, 1'b1, 24'd0));                        // BL over next
      emitStore(AL, 4'd2);
      emitStore(AL, LinkReg);
      emit(encDataReg(AL, FnCmp, 1'b1, 4'd0, 4'd1, 4'd1, 2'b00, 5'd0));
      emit(encBranch(NE, 1'b0, 24'd0));                        // Not taken
      emitStore(AL, 4'd5);
      emit(encBranch(EQ, 1'b0, 24'd1));                        // Skips two
      emitStore(AL, 4'd1);
      emitStore(AL, 4'd2);
      emitStore(AL, 4'd6);
      haltAddr = wordT'(progLen * 4);
      emit(encBranch(AL, 1'b0, 24'hFF_FFFE));                  // Final loop on itself
   endtask

   function automatic wordT readReg(regAddrT r);
      return (r == PcReg) ? mPc + 8 : mRegs[r];
   endfunction

   // Bit 0 of the code inverts the base test
   function automatic logic condHolds(logic [3:0] c, flagsT f);
      logic base;
      case (c[3:1])
         3'd0:    base = f.z;
         3'd1:    base = f.c;
         3'd2:    base = f.n;
         3'd3:    base = f.v;
         3'd4:    base = f.c & ~f.z;
         3'd5:    base = (f.n == f.v);
         3'd6:    base = ~f.z & (f.n == f.v);
         default: base = 1'b1;
      endcase
      return (c == 4'hf) ? 1'b0 : base ^ c[0];
   endfunction

   function automatic wordT shiftOp(wordT v, logic [1:0] t, logic [4:0] n);
      case (t)
         2'b00:   return v << n;
         2'b01:   return v >> n;
         2'b10:   return wordT'($signed(v) >>> n);
         default: return v;
      endcase
   endfunction

   // Reference model steps one instruction from the current model state
   function automatic stepT evalInstr(wordT ins);
      stepT        s;
      logic        hold;
      logic        arith;
      logic [3:0]  fn;
      logic [32:0] wide;
      wordT        a;
      wordT        b;
      wordT        res;
      s        = '0;
      s.flags  = mFlags;
      s.nextPc = mPc + 4;
      hold     = condHolds(ins[31:28], mFlags);
      a        = readReg(ins[19:16]);
      case (ins[27:26])
         2'b00:
         begin
            fn    = ins[24:21];
            b     = ins[25] ? {24'b0, ins[7:0]} : readReg(ins[3:0]);
            arith = (fn == FnAdd) || (fn == FnSub) || (fn == FnCmp);
            wide  = (fn == FnAdd) ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
            case (fn)
               FnAnd, FnTst: res = a & b;
               FnEor:        res = a ^ b;
               FnOrr:        res = a | b;
               FnBic:        res = a & ~b;
               FnMov:        res = ins[25] ? b : shiftOp(b, ins[6:5], ins[11:7]);
               default:      res = wide[31:0];
            endcase
            s.flags.n = res[31];
            s.flags.z = (res == '0);
            if (arith)
            begin
               s.flags.c = (fn == FnAdd) ? wide[32] : (a >= b);  // No borrow
               s.flags.v = (fn == FnAdd) ? (a[31] == b[31]) && (res[31] != a[31])
                                         : (a[31] != b[31]) && (res[31] != a[31]);
            end
            s.nzWe   = hold && ins[20];
            s.cvWe   = hold && ins[20] && arith;
            s.regWe  = hold && (fn != FnCmp) && (fn != FnTst);
            s.regIdx = ins[15:12];
            s.regVal = res;
         end
         2'b01:
         begin
            s.addr = a + {20'b0, ins[11:0]};
            if (ins[20])
            begin
               s.regWe  = hold;
               s.regIdx = ins[15:12];
               s.regVal = mDataMem[s.addr[9:2]];
            end
            else
            begin
               s.memWe = hold;
               s.data  = readReg(ins[15:12]);
            end
         end
         default:
         begin
            if (hold)
               s.nextPc = mPc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
            s.regWe  = hold && ins[24];
            s.regIdx = LinkReg;
            s.regVal = mPc + 4;
         end
      endcase
      if (s.regWe && (s.regIdx == PcReg))   // Result goes to pc
      begin
         s.nextPc = s.regVal;
         s.regWe  = 1'b0;
      end
      return s;
   endfunction

   task automatic applyStep(stepT s);
      if (s.memWe)
         mDataMem[s.addr[9:2]] = s.data;
      if (s.regWe)
         mRegs[s.regIdx] = s.regVal;
      if (s.nzWe)
      begin
         mFlags.n = s.flags.n;
         mFlags.z = s.flags.z;
      end
      if (s.cvWe)
      begin
         mFlags.c = s.flags.c;
         mFlags.v = s.flags.v;
      end
      mPc = s.nextPc;
   endtask

   // Mid-cycle compare while outputs are settled
   always @(negedge clk)
   begin : compare
      stepT want;
      if (!reset && !done)
      begin
         assert (pc === mPc)
         else
         begin
            $display("ERROR pc: got %h expected %h", pc, mPc);
            pcErrors++;
         end
         if (pcReady)
         begin
            want = evalInstr(progMem[mPc[9:2]]);
            assert (memWrite === want.memWe)
            else
            begin
               $display("ERROR memWrite: got %h expected %h", memWrite, want.memWe);
               storeErrors++;
            end
            if (want.memWe)
            begin
               assert (dataAddr === want.addr)
               else
               begin
                  $display("ERROR dataAddr: got %h expected %h", dataAddr, want.addr);
                  storeErrors++;
               end
               assert (writeData === want.data)
               else
               begin
                  $display("ERROR writeData: got %h expected %h", writeData, want.data);
                  storeErrors++;
               end
            end
            if (mPc == haltAddr)
               done = 1'b1;
            applyStep(want);
         end
         else
         begin
            assert (memWrite === 1'b0)   // Nothing commits while stalled
            else
            begin
               $display("ERROR memWrite: got %h expected %h", memWrite, 1'b0);
               storeErrors++;
            end
         end
      end
   end

   initial
   begin
      seed        = 32'h2cbb_b554;
      void'($urandom(seed));
      reset       = 1'b1;
      pcReady     = 1'b1;
      done        = 1'b0;
      pcErrors    = 0;
      storeErrors = 0;
      storeSlot   = 0;
      mPc         = '0;
      mFlags      = '0;
      for (int i = 0; i < MemWords; i++)
      begin
         progMem[i]  = {4'hf, 28'(i)};   // Never-execute filler
         dataMem[i]  = $urandom();
         mDataMem[i] = dataMem[i];
      end
      for (int r = 0; r < 15; r++)
         mRegs[r] = '0;
      progLen = 0;
      buildProgram();
      repeat (ResetCycles) @(posedge clk);
      #1 reset = 1'b0;
      while (!done)
      begin
         @(posedge clk);
         #1 pcReady = ($urandom() % 4) != 0;   // Stall about a quarter
      end
      @(posedge clk);
      $display("Errors: pc %0d, store %0d, total %0d", pcErrors, storeErrors,
               pcErrors + storeErrors);
      if (pcErrors + storeErrors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Watchdog sized from the program length
   initial
   begin
      @(negedge reset);
      #((progLen * StallAllowance + ResetCycles) * ClkPeriod);
      $display("Timeout: the core did not reach the final loop of the program in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/armPkg.sv
rtl/armCtrlIf.sv
rtl/armDecoder.sv
rtl/condUnit.sv
rtl/regFile.sv
rtl/armAlu.sv
rtl/armDatapath.sv
rtl/armCore.sv
tests/armCore_checker.sv
tests/armCoreTb.sv

// ==== Bender.yml ====
package:
  name: arm_core

sources:
  - files:
      - rtl/armPkg.sv
      - rtl/armCtrlIf.sv
      - rtl/armDecoder.sv
      - rtl/condUnit.sv
      - rtl/regFile.sv
      - rtl/armAlu.sv
      - rtl/armDatapath.sv
      - rtl/armCore.sv
  - target: test
    files:
      - tests/armCore_checker.sv
      - tests/armCoreTb.sv
